// File: Makefile
VERILATOR  = verilator
TOP        = tb_nic_interface_rx
FILE_LIST  = nic_interface_rx.f
LINT_FLAGS = --lint-only --timing
SIM_FLAGS  = --binary --timing --assert
BUILD_DIR  = obj_dir
PASS_MSG   = TB PASSED

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: nic_interface_rx.f
rx_pkg.sv
rx_desc_fifo.sv
rx_ingress.sv
rx_engine.sv
rx_dma_sink.sv
rx_buffer_ram.sv
nic_interface_rx.sv
tb_clock.sv
tb_nic_interface_rx.sv

// File: nic_interface_rx.sv
// NIC receive path top with descriptor FIFO, ingress, engine, DMA sink and RAM
module nic_interface_rx (
    input  logic              clk,
    input  logic              rst,
    input  rx_pkg::queue_t    desc_queue,
    input  rx_pkg::buf_addr_t desc_addr,
    input  logic              desc_valid,
    output logic              desc_ready,
    input  rx_pkg::word_t     rx_data,
    input  logic              rx_valid,
    input  logic              rx_last,
    output logic              rx_ready,
    input  logic              rd_en,
    input  rx_pkg::buf_addr_t rd_addr,
    output rx_pkg::word_t     rd_data,
    output logic              cpl_valid,
    output rx_pkg::queue_t    cpl_queue,
    output rx_pkg::buf_addr_t cpl_addr,
    output rx_pkg::len_t      cpl_len,
    output rx_pkg::csum_t     cpl_csum
);

    rx_pkg::queue_t    fifo_queue;
    rx_pkg::buf_addr_t fifo_addr;
    logic              fifo_valid;
    logic              fifo_ready;

    rx_pkg::buf_addr_t cmd_addr;
    logic              cmd_valid;
    logic              cmd_ready;

    rx_pkg::word_t     ing_data;
    logic              ing_valid;
    logic              ing_last;
    logic              ing_ready;

    logic              done;
    rx_pkg::len_t      done_len;
    rx_pkg::csum_t     csum;
    logic              csum_valid;
    logic              csum_ready;

    logic              wr_en;
    rx_pkg::buf_addr_t wr_addr;
    rx_pkg::word_t     wr_data;

    rx_desc_fifo desc_fifo_inst (
        .clk(clk), .rst(rst),
        .in_queue(desc_queue), .in_addr(desc_addr),
        .in_valid(desc_valid), .in_ready(desc_ready),
        .out_queue(fifo_queue), .out_addr(fifo_addr),
        .out_valid(fifo_valid), .out_ready(fifo_ready)
    );

    rx_ingress ingress_inst (
        .clk(clk), .rst(rst),
        .in_data(rx_data), .in_valid(rx_valid), .in_last(rx_last), .in_ready(rx_ready),
        .out_data(ing_data), .out_valid(ing_valid), .out_last(ing_last),
        .out_ready(ing_ready),
        .csum(csum), .csum_valid(csum_valid), .csum_ready(csum_ready)
    );

    rx_engine engine_inst (
        .clk(clk), .rst(rst),
        .rx_valid(rx_valid), .rx_ready(rx_ready), .rx_last(rx_last),
        .fifo_queue(fifo_queue), .fifo_addr(fifo_addr),
        .fifo_valid(fifo_valid), .fifo_ready(fifo_ready),
        .cmd_addr(cmd_addr), .cmd_valid(cmd_valid), .cmd_ready(cmd_ready),
        .done(done), .done_len(done_len),
        .csum(csum), .csum_valid(csum_valid), .csum_ready(csum_ready),
        .cpl_valid(cpl_valid), .cpl_queue(cpl_queue), .cpl_addr(cpl_addr),
        .cpl_len(cpl_len), .cpl_csum(cpl_csum)
    );

    rx_dma_sink dma_sink_inst (
        .clk(clk), .rst(rst),
        .cmd_addr(cmd_addr), .cmd_valid(cmd_valid), .cmd_ready(cmd_ready),
        .in_data(ing_data), .in_valid(ing_valid), .in_last(ing_last),
        .in_ready(ing_ready),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
        .done(done), .done_len(done_len)
    );

    rx_buffer_ram buffer_ram_inst (
        .clk(clk),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
        .rd_en(rd_en), .rd_addr(rd_addr), .rd_data(rd_data)
    );

endmodule

// File: rx_buffer_ram.sv
// Buffer RAM with one write port and one registered read port
module rx_buffer_ram (
    input  logic              clk,
    input  logic              wr_en,
    input  rx_pkg::buf_addr_t wr_addr,
    input  rx_pkg::word_t     wr_data,
    input  logic              rd_en,
    input  rx_pkg::buf_addr_t rd_addr,
    output rx_pkg::word_t     rd_data
);

    rx_pkg::word_t mem [rx_pkg::RAM_DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Data valid the cycle after rd_en
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

// File: rx_desc_fifo.sv
// Descriptor FIFO buffering queue number and buffer address pairs
module rx_desc_fifo (
    input  logic              clk,
    input  logic              rst,
    input  rx_pkg::queue_t    in_queue,
    input  rx_pkg::buf_addr_t in_addr,
    input  logic              in_valid,
    output logic              in_ready,
    output rx_pkg::queue_t    out_queue,
    output rx_pkg::buf_addr_t out_addr,
    output logic              out_valid,
    input  logic              out_ready
);

    rx_pkg::queue_t    queue_mem [rx_pkg::DESC_FIFO_DEPTH];
    rx_pkg::buf_addr_t addr_mem [rx_pkg::DESC_FIFO_DEPTH];

    logic [rx_pkg::DESC_PTR_WIDTH-1:0] wr_ptr;
    logic [rx_pkg::DESC_PTR_WIDTH-1:0] rd_ptr;
    logic [rx_pkg::DESC_PTR_WIDTH:0]   count;
    logic [rx_pkg::DESC_PTR_WIDTH:0]   count_next;
    logic                              wr;
    logic                              rd;

    assign wr = in_valid && in_ready;
    assign rd = out_valid && out_ready;

    assign out_valid = count != '0;
    assign out_queue = queue_mem[rd_ptr];
    assign out_addr  = addr_mem[rd_ptr];

    always_comb begin
        count_next = count;
        if (wr && !rd) begin
            count_next = count + 1'b1;
        end else if (!wr && rd) begin
            count_next = count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            in_ready <= 1'b0;
        end else begin
            if (wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count_next;
            // Registered ready drops on the edge that fills the FIFO
            in_ready <= count_next != (rx_pkg::DESC_PTR_WIDTH + 1)'(rx_pkg::DESC_FIFO_DEPTH);
        end
    end

    always_ff @(posedge clk) begin
        if (wr) begin
            queue_mem[wr_ptr] <= in_queue;
            addr_mem[wr_ptr]  <= in_addr;
        end
    end

    a_no_write_when_full: assert property (@(posedge clk) disable iff (rst)
        wr |-> count != (rx_pkg::DESC_PTR_WIDTH + 1)'(rx_pkg::DESC_FIFO_DEPTH));

endmodule

// File: rx_dma_sink.sv
// DMA sink writing one frame into the buffer RAM from a commanded address
module rx_dma_sink (
    input  logic              clk,
    input  logic              rst,
    input  rx_pkg::buf_addr_t cmd_addr,
    input  logic              cmd_valid,
    output logic              cmd_ready,
    input  rx_pkg::word_t     in_data,
    input  logic              in_valid,
    input  logic              in_last,
    output logic              in_ready,
    output logic              wr_en,
    output rx_pkg::buf_addr_t wr_addr,
    output rx_pkg::word_t     wr_data,
    output logic              done,
    output rx_pkg::len_t      done_len
);

    logic              busy;
    rx_pkg::buf_addr_t base_addr;
    rx_pkg::len_t      word_cnt;

    assign cmd_ready = !busy;
    assign in_ready  = busy;

    // Each accepted word goes straight to RAM at base plus word index
    assign wr_en   = in_valid && busy;
    assign wr_addr = base_addr + rx_pkg::buf_addr_t'(word_cnt);
    assign wr_data = in_data;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            word_cnt <= '0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            if (cmd_valid && cmd_ready) begin
                busy     <= 1'b1;
                word_cnt <= '0;
            end
            if (wr_en) begin
                word_cnt <= word_cnt + 1'b1;
                if (in_last) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_valid && cmd_ready) begin
            base_addr <= cmd_addr;
        end
        if (wr_en && in_last) begin
            done_len <= word_cnt + 1'b1;
        end
    end

    // Frames past the longest supported length would wrap the index
    a_frame_len: assert property (@(posedge clk) disable iff (rst)
        wr_en |-> word_cnt < rx_pkg::len_t'(rx_pkg::MAX_FRAME_WORDS));

endmodule

// File: rx_engine.sv
// RX engine pairing frame requests with descriptors and building completions
module rx_engine (
    input  logic              clk,
    input  logic              rst,
    input  logic              rx_valid,
    input  logic              rx_ready,
    input  logic              rx_last,
    input  rx_pkg::queue_t    fifo_queue,
    input  rx_pkg::buf_addr_t fifo_addr,
    input  logic              fifo_valid,
    output logic              fifo_ready,
    output rx_pkg::buf_addr_t cmd_addr,
    output logic              cmd_valid,
    input  logic              cmd_ready,
    input  logic              done,
    input  rx_pkg::len_t      done_len,
    input  rx_pkg::csum_t     csum,
    input  logic              csum_valid,
    output logic              csum_ready,
    output logic              cpl_valid,
    output rx_pkg::queue_t    cpl_queue,
    output rx_pkg::buf_addr_t cpl_addr,
    output rx_pkg::len_t      cpl_len,
    output rx_pkg::csum_t     cpl_csum
);

    logic                             frame_active;
    logic [rx_pkg::REQ_CNT_WIDTH-1:0] req_cnt;
    logic                             req_valid;
    logic                             req_pop;
    logic                             req_inc;

    // FSM state is low when idle and high while waiting for the frame to finish
    logic              wait_cpl;
    logic              done_seen;
    logic              cpl_fire;
    rx_pkg::queue_t    queue_hold;
    rx_pkg::buf_addr_t addr_hold;
    rx_pkg::len_t      len_hold;

    assign req_valid  = req_cnt != '0;
    assign fifo_ready = !wait_cpl && req_valid && cmd_ready;
    assign req_pop    = fifo_valid && fifo_ready;
    assign req_inc    = rx_valid && !frame_active && !req_pop;

    assign csum_ready = wait_cpl && (done || done_seen);
    assign cpl_fire   = csum_valid && csum_ready;

    assign cmd_addr  = addr_hold;
    assign cpl_queue = queue_hold;
    assign cpl_addr  = addr_hold;

    always_ff @(posedge clk) begin
        if (rst) begin
            frame_active <= 1'b0;
            req_cnt      <= '0;
            wait_cpl     <= 1'b0;
            done_seen    <= 1'b0;
            cmd_valid    <= 1'b0;
            cpl_valid    <= 1'b0;
        end else begin
            cpl_valid <= 1'b0;

            // A frame start counts as one request and a pop in the same cycle cancels it
            if (rx_valid && !frame_active) begin
                frame_active <= 1'b1;
                if (!req_pop) begin
                    req_cnt <= req_cnt + 1'b1;
                end
            end else if (req_pop) begin
                req_cnt <= req_cnt - 1'b1;
            end
            if (rx_valid && rx_ready && rx_last) begin
                frame_active <= 1'b0;
            end

            if (req_pop) begin
                wait_cpl  <= 1'b1;
                cmd_valid <= 1'b1;
            end
            if (cmd_valid && cmd_ready) begin
                cmd_valid <= 1'b0;
            end
            if (wait_cpl && done) begin
                done_seen <= 1'b1;
            end
            if (cpl_fire) begin
                cpl_valid <= 1'b1;
                wait_cpl  <= 1'b0;
                done_seen <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_pop) begin
            queue_hold <= fifo_queue;
            addr_hold  <= fifo_addr;
        end
        if (done) begin
            len_hold <= done_len;
        end
        if (cpl_fire) begin
            cpl_len  <= done ? done_len : len_hold;
            cpl_csum <= csum;
        end
    end

    a_req_cnt_no_overflow: assert property (@(posedge clk) disable iff (rst)
        req_inc |-> !(&req_cnt));

endmodule

// File: rx_ingress.sv
// RX ingress stage forwarding frame words and computing the frame checksum
module rx_ingress (
    input  logic          clk,
    input  logic          rst,
    input  rx_pkg::word_t in_data,
    input  logic          in_valid,
    input  logic          in_last,
    output logic          in_ready,
    output rx_pkg::word_t out_data,
    output logic          out_valid,
    output logic          out_last,
    input  logic          out_ready,
    output rx_pkg::csum_t csum,
    output logic          csum_valid,
    input  logic          csum_ready
);

    rx_pkg::csum_t acc;
    rx_pkg::csum_t acc_next;
    logic          accept;

    // Ones-complement add with the carry folded back into bit 0
    function automatic rx_pkg::csum_t csum_add(rx_pkg::csum_t a, rx_pkg::csum_t b);
        logic [rx_pkg::CSUM_WIDTH:0] s;
        s = {1'b0, a} + {1'b0, b};
        return s[rx_pkg::CSUM_WIDTH-1:0] + s[rx_pkg::CSUM_WIDTH];
    endfunction

    // Hold off the next frame until its checksum slot is free
    assign in_ready  = out_ready && !csum_valid;
    assign out_valid = in_valid && !csum_valid;
    assign out_data  = in_data;
    assign out_last  = in_last;

    assign accept = in_valid && in_ready;

    // Upper half first, then lower half
    assign acc_next = csum_add(csum_add(acc, in_data[31:16]), in_data[15:0]);

    always_ff @(posedge clk) begin
        if (rst) begin
            acc        <= '0;
            csum_valid <= 1'b0;
        end else begin
            if (csum_valid && csum_ready) begin
                csum_valid <= 1'b0;
            end
            if (accept) begin
                acc <= in_last ? '0 : acc_next;
                if (in_last) begin
                    csum_valid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept && in_last) begin
            csum <= acc_next;
        end
    end

    a_csum_held: assert property (@(posedge clk) disable iff (rst)
        (csum_valid && !csum_ready) |=> (csum_valid && $stable(csum)));

endmodule

// File: rx_pkg.sv
// RX path package holding the shared widths, depths and data types
package rx_pkg;

    // Frame data
    localparam int WORD_WIDTH = 32;
    localparam int CSUM_WIDTH = 16;

    // Descriptor fields
    localparam int QUEUE_WIDTH = 8;
    localparam int RAM_ADDR_WIDTH = 10;

    // Buffer RAM size in words
    localparam int RAM_DEPTH = 1024;

    // Longest frame in words and a length field that holds 1 to 64
    localparam int MAX_FRAME_WORDS = 64;
    localparam int LEN_WIDTH = 7;

    // Descriptor FIFO with a power of two depth
    localparam int DESC_FIFO_DEPTH = 8;
    localparam int DESC_PTR_WIDTH = $clog2(DESC_FIFO_DEPTH);

    // Pending receive request counter
    localparam int REQ_CNT_WIDTH = 6;

    typedef logic [WORD_WIDTH-1:0] word_t;

    typedef logic [QUEUE_WIDTH-1:0] queue_t;

    typedef logic [RAM_ADDR_WIDTH-1:0] buf_addr_t;

    typedef logic [LEN_WIDTH-1:0] len_t;

    typedef logic [CSUM_WIDTH-1:0] csum_t;

endpackage

// File: rx_stim.txt
# D queue addr gap : descriptor, queue and buffer address in hex, idle cycles before it
# F len words      : frame, length in words then each 32-bit word in hex
D 01 000 0
F 4 00000001 00020003 1234abcd 0000ffff
# Sent before its descriptor, which arrives late
F 3 deadbeef 01010101 80008000
D 02 040 60
D 03 080 0
D 04 0c0 0
D 05 100 0
F 2 11112222 33334444
F 5 a5a5a5a5 5a5a5a5a 00000000 fedcba98 76543210
F 1 cafef00d
# Halves that carry past 16 bits
D 06 3c0 0
F 4 ffffffff ffffffff ffff0001 fffe8000

// File: tb_clock.sv
// Testbench clock and reset generator with a 40 unit period and a 3 cycle reset
module tb_clock (
    output logic clk,
    output logic rst
);

    localparam int HALF_PERIOD = 20;
    localparam int RESET_CYCLES = 3;

    initial begin
        clk = 1'b0;
        forever begin
            #HALF_PERIOD clk = ~clk;
        end
    end

    // Reset drops after the third rising edge, like a registered signal
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// File: tb_nic_interface_rx.sv
// Testbench for the NIC receive path driven from a stimulus data file
module tb_nic_interface_rx;

    logic              clk;
    logic              rst;
    rx_pkg::queue_t    desc_queue;
    rx_pkg::buf_addr_t desc_addr;
    logic              desc_valid;
    logic              desc_ready;
    rx_pkg::word_t     rx_data;
    logic              rx_valid;
    logic              rx_last;
    logic              rx_ready;
    logic              rd_en;
    rx_pkg::buf_addr_t rd_addr;
    rx_pkg::word_t     rd_data;
    logic              cpl_valid;
    rx_pkg::queue_t    cpl_queue;
    rx_pkg::buf_addr_t cpl_addr;
    rx_pkg::len_t      cpl_len;
    rx_pkg::csum_t     cpl_csum;

    // Records from the stimulus file with descriptors and frames paired by index
    rx_pkg::queue_t    exp_queue [$];
    rx_pkg::buf_addr_t exp_addr [$];
    int                desc_gap [$];
    rx_pkg::len_t      frame_len [$];
    int                frame_base [$];
    rx_pkg::word_t     frame_words [$];
    int                num_records = 0;
    int                desc_accepted = 0;

    tb_clock clock_gen (
        .clk(clk),
        .rst(rst)
    );

    nic_interface_rx DUT (
        .clk(clk), .rst(rst),
        .desc_queue(desc_queue), .desc_addr(desc_addr),
        .desc_valid(desc_valid), .desc_ready(desc_ready),
        .rx_data(rx_data), .rx_valid(rx_valid), .rx_last(rx_last), .rx_ready(rx_ready),
        .rd_en(rd_en), .rd_addr(rd_addr), .rd_data(rd_data),
        .cpl_valid(cpl_valid), .cpl_queue(cpl_queue), .cpl_addr(cpl_addr),
        .cpl_len(cpl_len), .cpl_csum(cpl_csum)
    );

    // Descriptors taken by the FIFO on the transfer edge
    always @(posedge clk) begin
        if (!rst && desc_valid && desc_ready) begin
            desc_accepted <= desc_accepted + 1;
        end
    end

    task automatic fail_run(string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        if (act !== exp) begin
            fail_run($sformatf("Mismatch %s expected %b actual %b", name, exp, act));
        end
    endtask

    task automatic check_queue(string name, rx_pkg::queue_t exp, rx_pkg::queue_t act);
        if (act !== exp) begin
            fail_run($sformatf("Mismatch %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_addr(string name, rx_pkg::buf_addr_t exp, rx_pkg::buf_addr_t act);
        if (act !== exp) begin
            fail_run($sformatf("Mismatch %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_len(string name, rx_pkg::len_t exp, rx_pkg::len_t act);
        if (act !== exp) begin
            fail_run($sformatf("Mismatch %s expected %0d actual %0d", name, exp, act));
        end
    endtask

    task automatic check_csum(string name, rx_pkg::csum_t exp, rx_pkg::csum_t act);
        if (act !== exp) begin
            fail_run($sformatf("Mismatch %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_word(string name, rx_pkg::word_t exp, rx_pkg::word_t act);
        if (act !== exp) begin
            fail_run($sformatf("Mismatch %s expected %h actual %h", name, exp, act));
        end
    endtask

    // Sum of all 16-bit halves with the upper half first and carries folded into bit 0
    function automatic rx_pkg::csum_t expected_csum(int idx);
        logic [31:0]   s;
        rx_pkg::word_t w;
        s = '0;
        for (int j = 0; j < int'(frame_len[idx]); j++) begin
            w = frame_words[frame_base[idx] + j];
            s = s + 32'(w[31:16]);
            s = (s & 32'h0000_ffff) + (s >> 16);
            s = s + 32'(w[15:0]);
            s = (s & 32'h0000_ffff) + (s >> 16);
        end
        return rx_pkg::csum_t'(s);
    endfunction

    task automatic load_stimulus();
        int                fd;
        int                c;
        int                code;
        int                len;
        int                gap;
        rx_pkg::queue_t    q;
        rx_pkg::buf_addr_t a;
        rx_pkg::word_t     w;
        fd = $fopen("rx_stim.txt", "r");
        if (fd == 0) begin
            fail_run("Could not open the stimulus file rx_stim.txt");
        end
        c = $fgetc(fd);
        while (c != -1) begin
            if (c == int'("#")) begin
                // Skip a comment to the end of its line
                while (c != -1 && c != int'("\n")) begin
                    c = $fgetc(fd);
                end
            end else if (c == int'("D")) begin
                code = $fscanf(fd, "%h %h %d", q, a, gap);
                if (code != 3) begin
                    fail_run("A descriptor record in rx_stim.txt is malformed");
                end
                exp_queue.push_back(q);
                exp_addr.push_back(a);
                desc_gap.push_back(gap);
                num_records++;
            end else if (c == int'("F")) begin
                code = $fscanf(fd, "%d", len);
                if (code != 1 || len < 1 || len > rx_pkg::MAX_FRAME_WORDS) begin
                    fail_run("A frame record in rx_stim.txt has a bad length");
                end
                frame_base.push_back(frame_words.size());
                frame_len.push_back(rx_pkg::len_t'(len));
                for (int j = 0; j < len; j++) begin
                    code = $fscanf(fd, "%h", w);
                    if (code != 1) begin
                        fail_run("A frame record in rx_stim.txt is missing words");
                    end
                    frame_words.push_back(w);
                end
                num_records++;
            end
            c = $fgetc(fd);
        end
        $fclose(fd);
        if (exp_queue.size() != frame_len.size() || frame_len.size() == 0) begin
            fail_run("The stimulus file needs one descriptor per frame");
        end
    endtask

    task automatic drive_descriptors();
        for (int i = 0; i < exp_queue.size(); i++) begin
            repeat (desc_gap[i] + int'($urandom % 3)) @(negedge clk);
            desc_queue = exp_queue[i];
            desc_addr  = exp_addr[i];
            desc_valid = 1'b1;
            // desc_ready is registered and holds until the next rising edge
            while (!desc_ready) begin
                @(negedge clk);
            end
            @(negedge clk);
            desc_valid = 1'b0;
        end
    endtask

    task automatic drive_frames();
        int last;
        for (int f = 0; f < frame_len.size(); f++) begin
            // The first frame goes out with its descriptor already queued
            if (f == 0) begin
                while (desc_accepted == 0) begin
                    @(negedge clk);
                end
            end
            repeat (int'($urandom % 3)) @(negedge clk);
            last = int'(frame_len[f]) - 1;
            for (int j = 0; j <= last; j++) begin
                rx_data  = frame_words[frame_base[f] + j];
                rx_last  = (j == last);
                rx_valid = 1'b1;
                while (!rx_ready) begin
                    @(negedge clk);
                end
                // A frame must stall until its own descriptor is in the FIFO
                if (desc_accepted <= f) begin
                    fail_run($sformatf("rx_ready went high for frame %0d before its descriptor",
                        f));
                end
                @(negedge clk);
                rx_valid = 1'b0;
                rx_last  = 1'b0;
                if (j != last) begin
                    repeat (int'($urandom % 2)) @(negedge clk);
                end
            end
        end
    endtask

    task automatic watch_completions();
        int n;
        n = 0;
        while (n < frame_len.size()) begin
            @(negedge clk);
            if (cpl_valid) begin
                check_queue($sformatf("frame %0d queue", n), exp_queue[n], cpl_queue);
                check_addr($sformatf("frame %0d addr", n), exp_addr[n], cpl_addr);
                check_len($sformatf("frame %0d len", n), frame_len[n], cpl_len);
                check_csum($sformatf("frame %0d csum", n), expected_csum(n), cpl_csum);
                @(negedge clk);
                check_flag($sformatf("frame %0d cpl_valid pulse", n), 1'b0, cpl_valid);
                n++;
            end
        end
    endtask

    task automatic read_back_buffers();
        for (int f = 0; f < frame_len.size(); f++) begin
            for (int j = 0; j < int'(frame_len[f]); j++) begin
                rd_addr = exp_addr[f] + rx_pkg::buf_addr_t'(j);
                rd_en   = 1'b1;
                @(negedge clk);
                rd_en = 1'b0;
                check_word($sformatf("frame %0d ram word %0d", f, j),
                    frame_words[frame_base[f] + j], rd_data);
            end
        end
    endtask

    // Watchdog allowing 200 cycles per record
    initial begin
        wait (num_records > 0);
        repeat (num_records * 200) @(posedge clk);
        fail_run($sformatf("Timeout, the run did not finish within %0d cycles",
            num_records * 200));
    end

    initial begin
        void'($urandom(32'h9776));
        desc_queue = '0;
        desc_addr  = '0;
        desc_valid = 1'b0;
        rx_data    = '0;
        rx_valid   = 1'b0;
        rx_last    = 1'b0;
        rd_en      = 1'b0;
        rd_addr    = '0;
        load_stimulus();

        @(posedge clk);
        @(negedge clk);
        while (rst) begin
            check_flag("reset cpl_valid", 1'b0, cpl_valid);
            check_flag("reset rx_ready", 1'b0, rx_ready);
            check_flag("reset desc_ready", 1'b0, desc_ready);
            @(negedge clk);
        end
        repeat (4) begin
            check_flag("after reset cpl_valid", 1'b0, cpl_valid);
            check_flag("after reset rx_ready", 1'b0, rx_ready);
            @(negedge clk);
        end
        check_flag("after reset desc_ready", 1'b1, desc_ready);

        fork
            drive_descriptors();
            drive_frames();
            watch_completions();
        join

        read_back_buffers();
        $display("TB PASSED");
        $finish;
    end

endmodule
